// ==== include/bp_params.svh ====
`ifndef BP_PARAMS_SVH
`define BP_PARAMS_SVH

// ========================================
// Predictor geometry
// ========================================

`define BP_IP_WIDTH   64  // Fetch pointer width
`define BP_INDEX_BITS 8   // Low pointer bits select the entry
`define BP_TAG_BITS   56  // Remaining upper bits form the tag
`define BP_TABLE_SIZE 256 // One entry per index value

`define BP_STAT_WIDTH 16  // Accuracy counters wrap at this width

`endif

// ==== logic/bp_pkg.sv ====
`include "bp_params.svh"

package bp_pkg;

	// ========================================
	// Two-bit saturating counter
	// ========================================

	// The upper bit is the predicted direction
	typedef enum logic [1:0] {
		strong_not_taken = 2'd0,
		weak_not_taken   = 2'd1,
		weak_taken       = 2'd2,
		strong_taken     = 2'd3
	} counter_t;

	// ========================================
	// Table entry
	// ========================================

	typedef struct packed {
		logic [`BP_TAG_BITS-1:0] tag; // Upper pointer bits of the owning branch
		counter_t                ctr; // Direction state for that branch
	} entry_t;

endpackage

// ==== logic/bp_table_if.sv ====
`timescale 1ns/100ps
`include "bp_params.svh"

interface bp_table_if;

	// Training read port, answered combinationally by the table
	logic [`BP_INDEX_BITS-1:0] rd_index;
	bp_pkg::entry_t            rd_entry;

	// Single write port, committed on the rising edge with wr_en high
	logic                      wr_en;
	logic [`BP_INDEX_BITS-1:0] wr_index;
	bp_pkg::entry_t            wr_entry;

	modport trainer (
		output rd_index,
		input  rd_entry,
		output wr_en,
		output wr_index,
		output wr_entry
	);

	modport storage (
		input  rd_index,
		output rd_entry,
		input  wr_en,
		input  wr_index,
		input  wr_entry
	);

endinterface

// ==== logic/pattern_table.sv ====
`timescale 1ns/100ps
`include "bp_params.svh"

module pattern_table (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic [`BP_IP_WIDTH-1:0] lookup_ip,
	output logic                    prediction,
	bp_table_if.storage             tbl
);

	// Every entry starts as tag zero in the weakly taken state
	localparam bp_pkg::entry_t reset_entry = '{tag: '0, ctr: bp_pkg::weak_taken};

	bp_pkg::entry_t table_q [`BP_TABLE_SIZE];

	logic [`BP_INDEX_BITS-1:0] lookup_index;
	logic [`BP_TAG_BITS-1:0]   lookup_tag;
	bp_pkg::entry_t            lookup_entry;
	logic                      lookup_hit;

	// ========================================
	// Lookup port
	// ========================================

	assign lookup_index = lookup_ip[`BP_INDEX_BITS-1:0];
	assign lookup_tag   = lookup_ip[`BP_IP_WIDTH-1:`BP_INDEX_BITS];
	assign lookup_entry = table_q[lookup_index];

	assign lookup_hit = (lookup_entry.tag == lookup_tag); // A miss always predicts not taken
	assign prediction = lookup_hit && lookup_entry.ctr[1];

	// ========================================
	// Training port
	// ========================================

	assign tbl.rd_entry = table_q[tbl.rd_index]; // Same cycle read for the updater

	// A lookup in the write cycle still sees the old contents
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < `BP_TABLE_SIZE; i++) begin
				table_q[i] <= reset_entry;
			end
		end else if (tbl.wr_en) begin
			table_q[tbl.wr_index] <= tbl.wr_entry;
		end
	end

endmodule

// ==== logic/counter_update.sv ====
`timescale 1ns/100ps
`include "bp_params.svh"

module counter_update (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    lookup_valid,
	input  logic [`BP_IP_WIDTH-1:0] lookup_ip,
	input  logic                    resolve_valid,
	input  logic                    resolve_taken,
	bp_table_if.trainer             tbl
);

	logic [`BP_IP_WIDTH-1:0]   last_ip;
	logic [`BP_INDEX_BITS-1:0] last_index;
	logic [`BP_TAG_BITS-1:0]   last_tag;
	logic                      tag_hit;
	bp_pkg::counter_t          cur_ctr;
	bp_pkg::counter_t          next_ctr;

	// ========================================
	// Pointer of the lookup being resolved
	// ========================================

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			last_ip <= '0;
		end else if (lookup_valid) begin
			last_ip <= lookup_ip; // Resolve arrives one cycle later
		end
	end

	assign last_index = last_ip[`BP_INDEX_BITS-1:0];
	assign last_tag   = last_ip[`BP_IP_WIDTH-1:`BP_INDEX_BITS];

	assign tbl.rd_index = last_index;

	// ========================================
	// Counter step or allocation
	// ========================================

	assign cur_ctr = tbl.rd_entry.ctr;
	assign tag_hit = (tbl.rd_entry.tag == last_tag);

	always_comb begin
		next_ctr = cur_ctr;
		if (!tag_hit) begin
			// New owner starts weak in the resolved direction
			next_ctr = resolve_taken ? bp_pkg::weak_taken : bp_pkg::weak_not_taken;
		end else if (resolve_taken && cur_ctr != bp_pkg::strong_taken) begin
			next_ctr = bp_pkg::counter_t'(cur_ctr + 2'd1);
		end else if (!resolve_taken && cur_ctr != bp_pkg::strong_not_taken) begin
			next_ctr = bp_pkg::counter_t'(cur_ctr - 2'd1);
		end
	end

	assign tbl.wr_en    = resolve_valid; // Write lands on the edge ending the resolve cycle
	assign tbl.wr_index = last_index;
	assign tbl.wr_entry = '{tag: last_tag, ctr: next_ctr}; // Tag is unchanged on a hit

endmodule

// ==== logic/accuracy_tracker.sv ====
`timescale 1ns/100ps
`include "bp_params.svh"

module accuracy_tracker (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      lookup_valid,
	input  logic                      prediction,
	input  logic                      resolve_valid,
	input  logic                      resolve_taken,
	output logic [`BP_STAT_WIDTH-1:0] branch_count,
	output logic [`BP_STAT_WIDTH-1:0] mispredict_count
);

	logic issued_pred; // Direction given out with the last valid lookup

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			issued_pred <= 1'b0;
		end else if (lookup_valid) begin
			issued_pred <= prediction;
		end
	end

	// ========================================
	// Statistics
	// ========================================

	// Both counts wrap silently at full scale
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			branch_count     <= '0;
			mispredict_count <= '0;
		end else if (resolve_valid) begin
			branch_count <= branch_count + 1'b1;
			if (issued_pred != resolve_taken) begin
				mispredict_count <= mispredict_count + 1'b1;
			end
		end
	end

endmodule

// ==== logic/branch_predict_unit.sv ====
`timescale 1ns/100ps
`include "bp_params.svh"

module branch_predict_unit (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      lookup_valid,
	input  logic [`BP_IP_WIDTH-1:0]   lookup_ip,
	input  logic                      resolve_valid,
	input  logic                      resolve_taken,
	output logic                      prediction,
	output logic [`BP_STAT_WIDTH-1:0] branch_count,
	output logic [`BP_STAT_WIDTH-1:0] mispredict_count
);

	bp_table_if tbl_if (); // Training path between updater and table

	// ========================================
	// Storage and lookup
	// ========================================

	pattern_table pattern_table_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.lookup_ip  (lookup_ip),
		.prediction (prediction),
		.tbl        (tbl_if.storage)
	);

	// ========================================
	// Training
	// ========================================

	counter_update counter_update_i (
		.clk           (clk),
		.rst_n         (rst_n),
		.lookup_valid  (lookup_valid),
		.lookup_ip     (lookup_ip),
		.resolve_valid (resolve_valid),
		.resolve_taken (resolve_taken),
		.tbl           (tbl_if.trainer)
	);

	accuracy_tracker accuracy_tracker_i (
		.clk              (clk),
		.rst_n            (rst_n),
		.lookup_valid     (lookup_valid),
		.prediction       (prediction),
		.resolve_valid    (resolve_valid),
		.resolve_taken    (resolve_taken),
		.branch_count     (branch_count),
		.mispredict_count (mispredict_count)
	);

endmodule

// ==== testbench/bp_assert.sv ====
`timescale 1ns/100ps
`include "bp_params.svh"

module bp_assert (
	input logic                      clk,
	input logic                      rst_n,
	input logic                      lookup_valid,
	input logic [`BP_IP_WIDTH-1:0]   lookup_ip,
	input logic                      resolve_valid,
	input logic                      wr_en,
	input logic [`BP_INDEX_BITS-1:0] wr_index,
	input bp_pkg::entry_t            wr_entry,
	input logic [`BP_STAT_WIDTH-1:0] branch_count,
	input logic [`BP_STAT_WIDTH-1:0] mispredict_count
);

	// ========================================
	// Top-level protocol
	// ========================================

	resolve_after_lookup: assert property (@(posedge clk) disable iff (!rst_n)
		resolve_valid |-> $past(lookup_valid))
		else $error("resolve_valid was high without a lookup in the previous cycle");

	// A training write goes to the entry and tag of the lookup one cycle earlier
	write_targets_last_lookup: assert property (@(posedge clk) disable iff (!rst_n)
		wr_en |-> (wr_index == $past(lookup_ip[`BP_INDEX_BITS-1:0]))
			&& (wr_entry.tag == $past(lookup_ip[`BP_IP_WIDTH-1:`BP_INDEX_BITS])))
		else $error("Table write did not target the pointer of the previous lookup");

	// ========================================
	// Statistics only move forward
	// ========================================

	branch_count_steps: assert property (@(posedge clk) disable iff (!rst_n)
		branch_count == ($past(resolve_valid) ? $past(branch_count) + 1'b1
			: $past(branch_count)))
		else $error("branch_count did not advance by exactly one per resolve");

	mispredict_count_steps: assert property (@(posedge clk) disable iff (!rst_n)
		(mispredict_count == $past(mispredict_count))
		|| ($past(resolve_valid) && (mispredict_count == $past(mispredict_count) + 1'b1)))
		else $error("mispredict_count moved outside a resolve or by more than one");

endmodule

bind branch_predict_unit bp_assert bp_assert_i (
	.clk              (clk),
	.rst_n            (rst_n),
	.lookup_valid     (lookup_valid),
	.lookup_ip        (lookup_ip),
	.resolve_valid    (resolve_valid),
	.wr_en            (tbl_if.wr_en),
	.wr_index         (tbl_if.wr_index),
	.wr_entry         (tbl_if.wr_entry),
	.branch_count     (branch_count),
	.mispredict_count (mispredict_count)
);

// ==== testbench/tb_branch_predict_unit.sv ====
`timescale 1ns/100ps
`include "bp_params.svh"

module tb_branch_predict_unit;

	localparam int RESET_TIMEOUT = 20;   // Cycles allowed for reset to release
	localparam int MAX_LINES     = 1000; // Upper bound on stimulus lines
	localparam int MIN_LINES     = 30;   // Fewer lines than this means a truncated file

	logic                      clk;
	logic                      rst_n;
	logic                      lookup_valid;
	logic [`BP_IP_WIDTH-1:0]   lookup_ip;
	logic                      resolve_valid;
	logic                      resolve_taken;
	logic                      prediction;
	logic [`BP_STAT_WIDTH-1:0] branch_count;
	logic [`BP_STAT_WIDTH-1:0] mispredict_count;

	int   error_count   = 0;
	int   check_count   = 0;
	int   resolve_total = 0; // Resolves given in the data file
	int   miss_total    = 0; // Resolves that disagree with the preceding expected prediction
	logic last_expected = 1'b0;

	branch_predict_unit branch_predict_unit_i (
		.clk              (clk),
		.rst_n            (rst_n),
		.lookup_valid     (lookup_valid),
		.lookup_ip        (lookup_ip),
		.resolve_valid    (resolve_valid),
		.resolve_taken    (resolve_taken),
		.prediction       (prediction),
		.branch_count     (branch_count),
		.mispredict_count (mispredict_count)
	);

	// ========================================
	// Clock and reset
	// ========================================

	always #5 clk = ~clk;

	initial begin
		rst_n = 1'b0;
		repeat (2) @(posedge clk);
		#1 rst_n = 1'b1;
	end

	task automatic wait_reset_release(output bit released);
		int cycles;
		released = 1'b0;
		cycles   = 0;
		while (!released && cycles < RESET_TIMEOUT) begin
			@(posedge clk);
			cycles++;
			if (rst_n === 1'b1) begin
				released = 1'b1;
			end
		end
	endtask

	// ========================================
	// Checks
	// ========================================

	task automatic check_prediction(input int line_no, input logic expected);
		check_count++;
		assert (prediction === expected) else begin
			$display("Mismatch prediction at stimulus line %0d: got %h, expected %h",
				line_no, prediction, expected);
			error_count++;
		end
	endtask

	task automatic check_statistics();
		logic [`BP_STAT_WIDTH-1:0] exp_branches;
		logic [`BP_STAT_WIDTH-1:0] exp_misses;
		exp_branches = resolve_total[`BP_STAT_WIDTH-1:0]; // DUT counters wrap at this width
		exp_misses   = miss_total[`BP_STAT_WIDTH-1:0];
		check_count += 2;
		assert (branch_count === exp_branches) else begin
			$display("Mismatch branch_count: got %h, expected %h", branch_count, exp_branches);
			error_count++;
		end
		assert (mispredict_count === exp_misses) else begin
			$display("Mismatch mispredict_count: got %h, expected %h",
				mispredict_count, exp_misses);
			error_count++;
		end
	endtask

	// ========================================
	// Stimulus from the data file
	// ========================================

	task automatic run_stimulus(input int fd, output int line_count);
		string                   line;
		int                      fields;
		logic                    lv;
		logic [`BP_IP_WIDTH-1:0] ip;
		logic                    rv;
		logic                    tk;
		logic                    exp_pred;
		line_count = 0;
		while (line_count < MAX_LINES && $fgets(line, fd) != 0) begin
			if (line.len() < 2 || line[0] == "#") begin
				continue; // Header or blank line
			end
			fields = $sscanf(line, "%h %h %h %h %h", lv, ip, rv, tk, exp_pred);
			if (fields != 5) begin
				$display("Stimulus line %0d holds only %0d of its 5 fields", line_count + 1, fields);
				error_count++;
				break;
			end
			line_count++;
			@(posedge clk);
			#1;
			lookup_valid  = lv;
			lookup_ip     = ip;
			resolve_valid = rv;
			resolve_taken = tk;
			if (rv) begin
				resolve_total++;
				if (tk != last_expected) begin
					miss_total++;
				end
			end
			if (lv) begin
				last_expected = exp_pred; // Resolve on the next line refers to this lookup
			end
			#7;
			if (lv) begin
				check_prediction(line_count, exp_pred);
			end
		end
	endtask

	initial begin : main_sequence
		int fd;
		int used_lines;
		bit released;
		clk           = 1'b0;
		lookup_valid  = 1'b0;
		lookup_ip     = '0;
		resolve_valid = 1'b0;
		resolve_taken = 1'b0;
		wait_reset_release(released);
		if (!released) begin
			$display("Reset did not release within %0d cycles", RESET_TIMEOUT);
			error_count++;
		end else begin
			fd = $fopen("testbench/bp_input.txt", "r");
			if (fd == 0) begin
				$display("Could not open the stimulus file testbench/bp_input.txt");
				error_count++;
			end else begin
				run_stimulus(fd, used_lines);
				$fclose(fd);
				if (used_lines < MIN_LINES) begin
					$display("Stimulus file is short, only %0d lines were read", used_lines);
					error_count++;
				end
				@(posedge clk); // Last resolve lands on this edge
				#1;
				lookup_valid  = 1'b0;
				resolve_valid = 1'b0;
				resolve_taken = 1'b0;
				check_statistics();
			end
		end
		$display("Checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

// ==== testbench/bp_input.txt ====
# lookup_valid lookup_ip resolve_valid resolve_taken expected_prediction (all hex)
# One line per cycle; the expected prediction is ignored when lookup_valid is 0
1 0000000000000010 0 0 1
1 0000000000001234 1 1 0
1 0000000000001234 1 1 0
1 0000000000001234 1 1 1
1 0000000000001234 1 0 1
1 0000000000001234 1 0 1
1 0000000000001234 1 0 0
1 0000000000001234 1 0 0
0 0000000000000000 1 0 0
1 0000000000001234 0 0 0
1 0000000000000010 0 0 1
0 0000000000000000 1 1 0
1 0000000000000010 0 0 1
0 0000000000000000 1 0 0
1 0000000000000010 0 0 1
0 0000000000000000 1 1 0
1 0000000000005a20 0 0 0
0 0000000000000000 1 0 0
1 0000000000005a20 0 0 0
0 0000000000000000 1 1 0
1 0000000000005a20 0 0 1
0 0000000000000000 0 0 0
1 0000000000007720 0 0 0
0 0000000000000000 1 1 0
1 0000000000005a20 0 0 0
1 0000000000007720 1 0 1
1 0000000000007720 1 1 0
1 0000000000005a20 0 0 0
1 fedcba9876543210 0 0 0
1 0000000000000010 1 1 1
1 fedcba9876543210 1 1 1
1 0000000000000010 1 0 1
0 0000000000000000 1 1 0
1 0000000000000010 0 0 1
0 0000000000000000 0 0 0

// ==== filelist.f ====
+incdir+include
logic/bp_pkg.sv
logic/bp_table_if.sv
logic/pattern_table.sv
logic/counter_update.sv
logic/accuracy_tracker.sv
logic/branch_predict_unit.sv
testbench/bp_assert.sv
testbench/tb_branch_predict_unit.sv

// ==== Makefile ====
TOP := tb_branch_predict_unit

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f filelist.f --top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) > sim.log 2>&1 || echo "tests failed" >> sim.log
	cat sim.log
	! grep -q "tests failed" sim.log

clean:
	rm -rf obj_dir sim.log
